//--- rtl/exec_stage_capture.sv
// Follows fetched instructions through decode into execute, honouring core stalls
// Pulses o_exec_fire once per instruction that actually executes
`default_nettype none

module exec_stage_capture (
	input  wire                     i_clk,
	input  wire                     i_rst_n,
	input  wire trace_pkg::core_fetch_t i_core,
	input  wire [2:0]               i_interrupt,
	output logic [31:0]             o_exec_instr,
	output logic [31:0]             o_exec_addr,
	output logic                    o_exec_undefined,
	output logic                    o_exec_fire
);

	logic [31:0] dec_instr;
	logic [31:0] dec_addr;
	logic        dec_undefined;
	logic        dec_valid;
	logic [2:0]  dec_irq;       // Interrupt seen when this instruction was sampled
	logic        irq_allows;

	// Levels 0 and 7 leave the instruction alone, anything else overrides it
	assign irq_allows = (dec_irq == 3'd0) || (dec_irq == 3'd7);

	// ==================================================
	// Control state
	// ==================================================
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			dec_valid   <= 1'b0;
			o_exec_fire <= 1'b0;
		end
		else if (i_core.stall)
			o_exec_fire <= 1'b0;   // Pipeline frozen
		else
		begin
			dec_valid   <= i_core.valid;
			o_exec_fire <= dec_valid && irq_allows;
		end
	end

	// Payload registers, both stages advance only when the core advances
	always_ff @(posedge i_clk)
	begin
		if (!i_core.stall)
		begin
			if (i_core.valid)
			begin
				dec_instr     <= i_core.instr;
				dec_addr      <= i_core.addr;
				dec_undefined <= i_core.undefined;
				dec_irq       <= i_interrupt;
			end
			if (dec_valid)
			begin
				o_exec_instr     <= dec_instr;
				o_exec_addr      <= dec_addr;
				o_exec_undefined <= dec_undefined;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/instr_decoder.sv
// Combinational decode of an ARM v2 instruction word for the trace record
// Gives class, mnemonic code and the expanded rotated immediate
`default_nettype none

module instr_decoder (
	input  wire [31:0]             i_instr,
	output trace_pkg::instr_class_e o_iclass,
	output trace_pkg::mnemonic_e    o_mnem,
	output logic [31:0]            o_imm32
);

	logic [3:0]  opcode;
	logic [7:0]  imm8;
	logic [4:0]  rot_amt;
	logic [63:0] rot_dbl;

	assign opcode  = i_instr[24:21];
	assign imm8    = i_instr[7:0];
	assign rot_amt = {i_instr[11:8], 1'b0};   // Rotate field counts in pairs of bits

	// Low half of a doubled word shifted right is a rotate
	assign rot_dbl = {24'h0, imm8, 24'h0, imm8} >> rot_amt;

	// ==================================================
	// Class, order matters
	// ==================================================
	always_comb
	begin
		if ({i_instr[27:23], i_instr[21:20], i_instr[11:4]} == 15'b00010_00_00001001)
			o_iclass = trace_pkg::SWAP;       // Shares the REGOP space
		else if ({i_instr[27:22], i_instr[7:4]} == 10'b000000_1001)
			o_iclass = trace_pkg::MULT;       // Shares the REGOP space
		else if (i_instr[27:26] == 2'b00)
			o_iclass = trace_pkg::REGOP;
		else if (i_instr[27:26] == 2'b01)
			o_iclass = trace_pkg::TRANS;
		else if (i_instr[27:25] == 3'b100)
			o_iclass = trace_pkg::MTRANS;
		else if (i_instr[27:25] == 3'b101)
			o_iclass = trace_pkg::BRANCH;
		else if (i_instr[27:25] == 3'b110)
			o_iclass = trace_pkg::CODTRANS;
		else if ({i_instr[27:24], i_instr[4]} == 5'b1110_0)
			o_iclass = trace_pkg::COREGOP;
		else if ({i_instr[27:24], i_instr[4]} == 5'b1110_1)
			o_iclass = trace_pkg::CORTRANS;
		else
			o_iclass = trace_pkg::SWI;
	end

	// ==================================================
	// Mnemonic
	// ==================================================
	always_comb
	begin
		o_mnem = trace_pkg::MN_UNKNOWN;
		case (o_iclass)
			trace_pkg::REGOP:
			begin
				case (opcode)
					trace_pkg::AND: o_mnem = trace_pkg::MN_AND;
					trace_pkg::EOR: o_mnem = trace_pkg::MN_EOR;
					trace_pkg::SUB: o_mnem = trace_pkg::MN_SUB;
					trace_pkg::RSB: o_mnem = trace_pkg::MN_RSB;
					trace_pkg::ADD: o_mnem = trace_pkg::MN_ADD;
					trace_pkg::ADC: o_mnem = trace_pkg::MN_ADC;
					trace_pkg::SBC: o_mnem = trace_pkg::MN_SBC;
					trace_pkg::RSC: o_mnem = trace_pkg::MN_RSC;
					trace_pkg::TST: o_mnem = trace_pkg::MN_TST;
					trace_pkg::TEQ: o_mnem = trace_pkg::MN_TEQ;
					trace_pkg::CMP: o_mnem = trace_pkg::MN_CMP;
					trace_pkg::CMN: o_mnem = trace_pkg::MN_CMN;
					trace_pkg::ORR: o_mnem = trace_pkg::MN_ORR;
					trace_pkg::MOV: o_mnem = trace_pkg::MN_MOV;
					trace_pkg::BIC: o_mnem = trace_pkg::MN_BIC;
					default:        o_mnem = trace_pkg::MN_MVN;
				endcase
			end
			trace_pkg::MULT:
				o_mnem = i_instr[21] ? trace_pkg::MN_MLA : trace_pkg::MN_MUL;   // Accumulate
			trace_pkg::SWAP:
				o_mnem = i_instr[22] ? trace_pkg::MN_SWPB : trace_pkg::MN_SWP;  // Byte
			trace_pkg::TRANS:
			begin
				case ({i_instr[22], i_instr[20]})    // Byte, load
					2'b00:   o_mnem = trace_pkg::MN_STR;
					2'b01:   o_mnem = trace_pkg::MN_LDR;
					2'b10:   o_mnem = trace_pkg::MN_STRB;
					default: o_mnem = trace_pkg::MN_LDRB;
				endcase
			end
			trace_pkg::MTRANS:
				o_mnem = i_instr[20] ? trace_pkg::MN_LDM : trace_pkg::MN_STM;
			trace_pkg::BRANCH:
				o_mnem = i_instr[24] ? trace_pkg::MN_BL : trace_pkg::MN_B;      // Link bit
			trace_pkg::CODTRANS:
				o_mnem = i_instr[20] ? trace_pkg::MN_LDC : trace_pkg::MN_STC;
			trace_pkg::COREGOP:
				o_mnem = trace_pkg::MN_CDP;
			trace_pkg::CORTRANS:
				o_mnem = i_instr[20] ? trace_pkg::MN_MRC : trace_pkg::MN_MCR;
			trace_pkg::SWI:
				o_mnem = trace_pkg::MN_SWI;
			default:
				o_mnem = trace_pkg::MN_UNKNOWN;
		endcase
	end

	// Only a data processing op with I bit set carries an immediate
	assign o_imm32 = (o_iclass == trace_pkg::REGOP && i_instr[25]) ? rot_dbl[31:0] : 32'h0;

endmodule

`default_nettype wire

//--- rtl/instr_trace_top.sv
// Instruction trace unit, taps the core fetch stage and serves records over Wishbone
// Sets the trace FIFO depth for the blocks below
`default_nettype none

module instr_trace_top #(
	parameter int TRACE_DEPTH = 16
) (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire trace_pkg::core_fetch_t i_core,
	input  wire [2:0]                   i_interrupt,
	input  wire                         i_wb_cyc,
	input  wire                         i_wb_stb,
	input  wire                         i_wb_we,
	input  wire [2:0]                   i_wb_adr,
	input  wire [31:0]                  i_wb_dat,
	output logic [31:0]                 o_wb_dat,
	output logic                        o_wb_ack,
	output logic                        o_trace_nonempty
);

	logic [31:0]             exec_instr;
	logic [31:0]             exec_addr;
	logic                    exec_undefined;
	logic                    exec_fire;
	trace_pkg::instr_class_e iclass;
	trace_pkg::mnemonic_e    mnem;
	logic [31:0]             imm32;
	trace_pkg::trace_rec_t   push_rec;
	trace_pkg::trace_rec_t   head_rec;
	logic                    fifo_empty;
	logic [$clog2(TRACE_DEPTH):0] fifo_count;
	logic                    fifo_overflow;
	logic                    pop;
	logic                    clr_ovf;

	exec_stage_capture u_capture (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_core(i_core), .i_interrupt(i_interrupt),
		.o_exec_instr(exec_instr), .o_exec_addr(exec_addr),
		.o_exec_undefined(exec_undefined), .o_exec_fire(exec_fire)
	);

	instr_decoder u_decoder (
		.i_instr(exec_instr), .o_iclass(iclass), .o_mnem(mnem), .o_imm32(imm32)
	);

	assign push_rec = '{addr: exec_addr, instr: exec_instr, imm32: imm32,
		iclass: iclass, mnem: mnem, undefined: exec_undefined};

	trace_fifo #(.TRACE_DEPTH(TRACE_DEPTH)) u_fifo (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(exec_fire), .i_rec(push_rec),
		.i_pop(pop), .i_clr_ovf(clr_ovf), .o_head(head_rec), .o_empty(fifo_empty),
		.o_count(fifo_count), .o_overflow(fifo_overflow)
	);

	trace_wb_slave #(.TRACE_DEPTH(TRACE_DEPTH)) u_wb_slave (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .i_head(head_rec),
		.i_empty(fifo_empty), .i_count(fifo_count), .i_overflow(fifo_overflow),
		.o_pop(pop), .o_clr_ovf(clr_ovf), .o_nonempty(o_trace_nonempty)
	);

endmodule

`default_nettype wire

//--- rtl/trace_fifo.sv
// Circular buffer of trace records between the execute tap and the bus slave
// Never stalls the writer, a push while full is lost and flagged
`default_nettype none

module trace_fifo #(
	parameter int TRACE_DEPTH = 16    // Power of two
) (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_push,
	input  wire trace_pkg::trace_rec_t     i_rec,
	input  wire                            i_pop,
	input  wire                            i_clr_ovf,
	output trace_pkg::trace_rec_t          o_head,
	output logic                           o_empty,
	output logic [$clog2(TRACE_DEPTH):0]   o_count,
	output logic                           o_overflow
);

	localparam int PTR_W = $clog2(TRACE_DEPTH);

	trace_pkg::trace_rec_t mem [TRACE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full    = o_count == (PTR_W + 1)'(TRACE_DEPTH);
	assign o_empty = o_count == '0;
	assign do_push = i_push && !full;
	assign do_pop  = i_pop && !o_empty;
	assign o_head  = mem[rd_ptr];   // Show-ahead

	always_ff @(posedge i_clk)
	begin
		if (do_push)
			mem[wr_ptr] <= i_rec;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			o_count    <= '0;
			o_overflow <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
			// A lost record in the same cycle as a clear still counts
			if (i_push && full)
				o_overflow <= 1'b1;
			else if (i_clr_ovf)
				o_overflow <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/trace_pkg.sv
// Shared types and constants for the instruction trace unit
// Referenced by scoped name from every RTL block
`default_nettype none

package trace_pkg;

	// ==================================================
	// Instruction class and mnemonic codes
	// ==================================================
	typedef enum logic [3:0] {
		REGOP    = 4'd0,
		MULT     = 4'd1,
		SWAP     = 4'd2,
		TRANS    = 4'd3,
		MTRANS   = 4'd4,
		BRANCH   = 4'd5,
		CODTRANS = 4'd6,
		COREGOP  = 4'd7,
		CORTRANS = 4'd8,
		SWI      = 4'd9
	} instr_class_e;

	// Alphabetical, codes 0 to 33
	typedef enum logic [5:0] {
		MN_ADC, MN_ADD, MN_AND, MN_B,
		MN_BIC, MN_BL, MN_CDP, MN_CMN,
		MN_CMP, MN_EOR, MN_LDC, MN_LDM,
		MN_LDR, MN_LDRB, MN_MCR, MN_MLA,
		MN_MOV, MN_MRC, MN_MUL, MN_MVN,
		MN_ORR, MN_RSB, MN_RSC, MN_SBC,
		MN_STC, MN_STM, MN_STR, MN_STRB,
		MN_SUB, MN_SWI, MN_SWP, MN_SWPB,
		MN_TEQ, MN_TST,
		MN_UNKNOWN = 6'd63
	} mnemonic_e;

	// Data processing opcodes, bits 24:21
	localparam logic [3:0] AND = 4'h0;
	localparam logic [3:0] EOR = 4'h1;
	localparam logic [3:0] SUB = 4'h2;
	localparam logic [3:0] RSB = 4'h3;
	localparam logic [3:0] ADD = 4'h4;
	localparam logic [3:0] ADC = 4'h5;
	localparam logic [3:0] SBC = 4'h6;
	localparam logic [3:0] RSC = 4'h7;
	localparam logic [3:0] TST = 4'h8;
	localparam logic [3:0] TEQ = 4'h9;
	localparam logic [3:0] CMP = 4'ha;
	localparam logic [3:0] CMN = 4'hb;
	localparam logic [3:0] ORR = 4'hc;
	localparam logic [3:0] MOV = 4'hd;
	localparam logic [3:0] BIC = 4'he;
	localparam logic [3:0] MVN = 4'hf;

	// ==================================================
	// Core fetch bundle and trace record
	// ==================================================
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] addr;
		logic        valid;
		logic        undefined;
		logic        stall;     // Fetch stage held by the core
	} core_fetch_t;

	typedef struct packed {
		logic [31:0]  addr;
		logic [31:0]  instr;
		logic [31:0]  imm32;     // Zero unless REGOP with immediate operand
		instr_class_e iclass;
		mnemonic_e    mnem;
		logic         undefined;
	} trace_rec_t;

	// Register map, word offsets on the bus
	localparam logic [2:0] REG_STATUS = 3'd0;   // Count, empty, overflow
	localparam logic [2:0] REG_ADDR   = 3'd1;
	localparam logic [2:0] REG_INSTR  = 3'd2;
	localparam logic [2:0] REG_IMM    = 3'd3;
	localparam logic [2:0] REG_INFO   = 3'd4;   // Class, mnemonic, undefined
	localparam logic [2:0] REG_POP    = 3'd5;   // Any write drops the head record

endpackage

`default_nettype wire

//--- rtl/trace_wb_slave.sv
// Wishbone classic register slave for reading trace records
// Exposes head record and status, writes turn into pop and clear strobes
`default_nettype none

module trace_wb_slave #(
	parameter int TRACE_DEPTH = 16    // Up to 128 so the count fits status bits 7:0
) (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_wb_cyc,
	input  wire                            i_wb_stb,
	input  wire                            i_wb_we,
	input  wire [2:0]                      i_wb_adr,
	input  wire [31:0]                     i_wb_dat,
	output logic [31:0]                    o_wb_dat,
	output logic                           o_wb_ack,
	input  wire trace_pkg::trace_rec_t     i_head,
	input  wire                            i_empty,
	input  wire [$clog2(TRACE_DEPTH):0]    i_count,
	input  wire                            i_overflow,
	output logic                           o_pop,
	output logic                           o_clr_ovf,
	output logic                           o_nonempty
);

	logic        req;
	logic        wr_req;
	logic [31:0] rd_data;

	// No new request is taken in the ack cycle
	assign req    = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign wr_req = req && i_wb_we;

	// Strobes land on the edge that raises ack
	assign o_pop      = wr_req && (i_wb_adr == trace_pkg::REG_POP);
	assign o_clr_ovf  = wr_req && (i_wb_adr == trace_pkg::REG_STATUS) && i_wb_dat[9];   // W1C
	assign o_nonempty = !i_empty;

	// ==================================================
	// Read mux
	// ==================================================
	always_comb
	begin
		rd_data = 32'h0;
		case (i_wb_adr)
			trace_pkg::REG_STATUS:
			begin
				rd_data[$clog2(TRACE_DEPTH):0] = i_count;
				rd_data[8]                     = i_empty;
				rd_data[9]                     = i_overflow;
			end
			trace_pkg::REG_ADDR:
				rd_data = i_head.addr;
			trace_pkg::REG_INSTR:
				rd_data = i_head.instr;
			trace_pkg::REG_IMM:
				rd_data = i_head.imm32;
			trace_pkg::REG_INFO:
			begin
				rd_data[3:0]  = i_head.iclass;
				rd_data[9:4]  = i_head.mnem;
				rd_data[10]   = i_head.undefined;
			end
			default:
				rd_data = 32'h0;   // REG_POP and unmapped offsets
		endcase
	end

	// Single-cycle ack one clock after the request
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= req;
	end

	always_ff @(posedge i_clk)
	begin
		if (req && !i_wb_we)
			o_wb_dat <= rd_data;   // Valid with ack
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the trace unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module instr_trace_tb -o sim_instr_trace
./obj_dir/sim_instr_trace > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation finished without failures"

//--- tb/instr_trace_tb.sv
// Self-checking testbench for the instruction trace unit
// Drives fetch traffic into the core port and reads the records back over Wishbone
`default_nettype none

module instr_trace_tb;

	localparam int DEPTH = 16;

	logic                   i_clk;
	logic                   i_rst_n;
	trace_pkg::core_fetch_t core;
	logic [2:0]             irq;
	logic                   wb_cyc;
	logic                   wb_stb;
	logic                   wb_we;
	logic [2:0]             wb_adr;
	logic [31:0]            wb_dat_w;
	logic [31:0]            wb_dat_r;
	logic                   wb_ack;
	logic                   nonempty;

	int                    errors;
	int                    checks;
	logic [31:0]           next_addr;
	trace_pkg::trace_rec_t exp_q [$];       // Expected records in FIFO order
	trace_pkg::mnemonic_e  dp_table [16];   // Data processing mnemonic per opcode

	instr_trace_top #(.TRACE_DEPTH(DEPTH)) i_instr_trace_top (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_core(core), .i_interrupt(irq),
		.i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_adr(wb_adr),
		.i_wb_dat(wb_dat_w), .o_wb_dat(wb_dat_r), .o_wb_ack(wb_ack),
		.o_trace_nonempty(nonempty)
	);

	always #4 i_clk = ~i_clk;

	// ==================================================
	// Reference model of the instruction set
	// ==================================================
	// f[0] is the I, accumulate, byte, link or load bit by class
	// f[1] is the byte bit for TRANS
	function automatic logic [31:0] encode(input logic [3:0] cls, input logic [3:0] op,
		input logic [1:0] f, input logic [31:0] r);
		case (cls)
			trace_pkg::REGOP:    encode = {4'he, 2'b00, f[0], op, r[20:5], r[4] & f[0], r[3:0]};
			trace_pkg::MULT:     encode = {4'he, 6'b000000, f[0], r[20:8], 4'b1001, r[3:0]};
			trace_pkg::SWAP:     encode = {4'he, 5'b00010, f[0], 2'b00, r[19:12], 8'h09, r[3:0]};
			trace_pkg::TRANS:    encode = {4'he, 2'b01, r[25:23], f[1], r[21], f[0], r[19:0]};
			trace_pkg::MTRANS:   encode = {4'he, 3'b100, r[24:21], f[0], r[19:0]};
			trace_pkg::BRANCH:   encode = {4'he, 3'b101, f[0], r[23:0]};
			trace_pkg::CODTRANS: encode = {4'he, 3'b110, r[24:21], f[0], r[19:0]};
			trace_pkg::COREGOP:  encode = {4'he, 4'b1110, r[23:5], 1'b0, r[3:0]};
			trace_pkg::CORTRANS: encode = {4'he, 4'b1110, r[23:21], f[0], r[19:5], 1'b1, r[3:0]};
			default:             encode = {4'he, 4'b1111, r[23:0]};   // SWI
		endcase
	endfunction

	function automatic trace_pkg::mnemonic_e mnem_of(input logic [3:0] cls,
		input logic [3:0] op, input logic [1:0] f);
		case (cls)
			trace_pkg::REGOP:    mnem_of = dp_table[op];
			trace_pkg::MULT:     mnem_of = f[0] ? trace_pkg::MN_MLA : trace_pkg::MN_MUL;
			trace_pkg::SWAP:     mnem_of = f[0] ? trace_pkg::MN_SWPB : trace_pkg::MN_SWP;
			trace_pkg::TRANS:    mnem_of = f[1] ? (f[0] ? trace_pkg::MN_LDRB : trace_pkg::MN_STRB)
				: (f[0] ? trace_pkg::MN_LDR : trace_pkg::MN_STR);
			trace_pkg::MTRANS:   mnem_of = f[0] ? trace_pkg::MN_LDM : trace_pkg::MN_STM;
			trace_pkg::BRANCH:   mnem_of = f[0] ? trace_pkg::MN_BL : trace_pkg::MN_B;
			trace_pkg::CODTRANS: mnem_of = f[0] ? trace_pkg::MN_LDC : trace_pkg::MN_STC;
			trace_pkg::COREGOP:  mnem_of = trace_pkg::MN_CDP;
			trace_pkg::CORTRANS: mnem_of = f[0] ? trace_pkg::MN_MRC : trace_pkg::MN_MCR;
			default:             mnem_of = trace_pkg::MN_SWI;
		endcase
	endfunction

	// Immediate operand as imm8 rotated right by twice the rotate field
	function automatic logic [31:0] ror_imm(input logic [7:0] imm8, input logic [3:0] rot);
		logic [31:0] x;
		int          amt;
		x   = {24'h0, imm8};
		amt = 2 * rot;
		if (amt == 0)
			ror_imm = x;
		else
			ror_imm = (x >> amt) | (x << (32 - amt));
	endfunction

	function automatic logic [31:0] status_word(input int cnt, input logic ovf);
		status_word = {22'h0, ovf, cnt == 0, 8'(cnt)};
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// ==================================================
	// Bus and core drivers
	// ==================================================
	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
		output logic [31:0] rdata);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		rdata    = 32'h0;
		waited   = 0;
		while (!wb_ack && waited < 16)
		begin
			@(posedge i_clk);
			#1;
			waited++;
		end
		if (wb_ack)
		begin
			rdata = wb_dat_r;
			check_value("wb ack latency", 32'd1, 32'(waited));   // One clock after request
		end
		else
		begin
			errors++;
			$display("Timeout: no Wishbone ack for offset %0d", adr);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge i_clk);   // Let ack fall before the next access
		#1;
		check_value("wb ack pulse", 32'h0, 32'(wb_ack));
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdata);
		wb_access(1'b0, adr, 32'h0, rdata);
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic core_cycle(input logic valid, input logic stall, input logic [31:0] instr,
		input logic undef, input logic [2:0] level);
		core.valid     = valid;
		core.stall     = stall;
		core.instr     = instr;
		core.addr      = next_addr;
		core.undefined = undef;
		irq            = level;
		@(posedge i_clk);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) core_cycle(1'b0, 1'b0, 32'h0, 1'b0, 3'd0);
	endtask

	// One instruction followed by a random run of stall and bubble cycles
	task automatic issue(input logic [3:0] cls, input logic [3:0] op, input logic [1:0] f,
		input logic [2:0] level, input int max_gap, input logic keep);
		logic [31:0]           r;
		trace_pkg::trace_rec_t rec;
		logic                  stall;
		r             = $urandom;
		rec.addr      = next_addr;
		rec.instr     = encode(cls, op, f, r);
		rec.imm32     = 32'h0;
		rec.iclass    = trace_pkg::instr_class_e'(cls);
		rec.mnem      = mnem_of(cls, op, f);
		rec.undefined = 1'($urandom_range(0, 1));
		if (cls == trace_pkg::REGOP && f[0])
			rec.imm32 = ror_imm(rec.instr[7:0], rec.instr[11:8]);
		if (keep && (level == 3'd0 || level == 3'd7))
			exp_q.push_back(rec);   // Other levels override the instruction
		core_cycle(1'b1, 1'b0, rec.instr, rec.undefined, level);
		next_addr += 32'd4;
		repeat ($urandom_range(0, max_gap))
		begin
			stall = 1'($urandom_range(0, 1));
			core_cycle(stall & 1'($urandom_range(0, 1)), stall, $urandom, 1'b0, 3'($urandom));
		end
	endtask

	// Drain the pipeline and pop every expected record after reading it
	task automatic check_records(input string name);
		logic [31:0]           d;
		trace_pkg::trace_rec_t rec;
		idle(4);
		check_value({name, " nonempty"}, 32'(exp_q.size() != 0), 32'(nonempty));
		wb_read(trace_pkg::REG_STATUS, d);
		check_value({name, " status"}, status_word(exp_q.size(), 1'b0), d);
		while (exp_q.size() > 0)
		begin
			rec = exp_q.pop_front();
			wb_read(trace_pkg::REG_ADDR, d);
			check_value({name, " addr"}, rec.addr, d);
			wb_read(trace_pkg::REG_INSTR, d);
			check_value({name, " instr"}, rec.instr, d);
			wb_read(trace_pkg::REG_IMM, d);
			check_value({name, " imm"}, rec.imm32, d);
			wb_read(trace_pkg::REG_INFO, d);
			check_value({name, " info"}, {21'h0, rec.undefined, rec.mnem, rec.iclass}, d);
			wb_write(trace_pkg::REG_POP, 32'h0);
		end
		wb_read(trace_pkg::REG_STATUS, d);
		check_value({name, " final status"}, status_word(0, 1'b0), d);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial
	begin
		logic [31:0] d;
		int          nv;
		i_clk    = 1'b0;
		i_rst_n  = 1'b0;
		core     = '0;
		irq      = 3'd0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 3'd0;
		wb_dat_w = 32'h0;
		errors   = 0;
		checks   = 0;
		void'($urandom(67186));
		next_addr = {4'h0, 26'($urandom), 2'b00};
		dp_table = '{trace_pkg::MN_AND, trace_pkg::MN_EOR, trace_pkg::MN_SUB, trace_pkg::MN_RSB,
			trace_pkg::MN_ADD, trace_pkg::MN_ADC, trace_pkg::MN_SBC, trace_pkg::MN_RSC,
			trace_pkg::MN_TST, trace_pkg::MN_TEQ, trace_pkg::MN_CMP, trace_pkg::MN_CMN,
			trace_pkg::MN_ORR, trace_pkg::MN_MOV, trace_pkg::MN_BIC, trace_pkg::MN_MVN};
		repeat (3) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;

		// Empty state after reset and a pop on empty
		check_value("reset nonempty", 32'h0, 32'(nonempty));
		check_value("reset ack", 32'h0, 32'(wb_ack));
		wb_read(trace_pkg::REG_STATUS, d);
		check_value("reset status", status_word(0, 1'b0), d);
		wb_write(trace_pkg::REG_POP, 32'h0);
		wb_read(trace_pkg::REG_STATUS, d);
		check_value("empty pop status", status_word(0, 1'b0), d);

		// Every mnemonic once
		for (int op = 0; op < 16; op++)
		begin
			issue(trace_pkg::REGOP, 4'(op), {1'b0, 1'($urandom)}, 3'd0, 3, 1'b1);
			if (exp_q.size() == 8)
				check_records("decode");
		end
		for (int c = 1; c < 10; c++)
		begin
			nv = (c == trace_pkg::TRANS) ? 4 :
				(c == trace_pkg::COREGOP || c == trace_pkg::SWI) ? 1 : 2;
			for (int f = 0; f < nv; f++)
			begin
				issue(4'(c), 4'h0, 2'(f), $urandom_range(0, 1) ? 3'd7 : 3'd0, 3, 1'b1);
				if (exp_q.size() == 8)
					check_records("decode");
			end
		end
		check_records("decode");

		// Immediate operand with the I bit mostly set
		for (int k = 0; k < 16; k++)
		begin
			issue(trace_pkg::REGOP, 4'($urandom), (k % 4 == 0) ? 2'b00 : 2'b01, 3'd0, 2, 1'b1);
			if (exp_q.size() == 8)
				check_records("immediate");
		end
		check_records("immediate");

		// Long stall and bubble runs
		for (int k = 0; k < 12; k++)
		begin
			issue(4'($urandom_range(0, 9)), 4'($urandom), 2'($urandom), 3'd0, 8, 1'b1);
			if (exp_q.size() == 8)
				check_records("stall");
		end
		check_records("stall");

		// Each interrupt level twice
		for (int k = 0; k < 16; k++)
			issue(4'($urandom_range(0, 9)), 4'($urandom), 2'($urandom), 3'(k), 2, 1'b1);
		check_records("interrupt");

		// FIFO overrun keeps the oldest records
		for (int k = 0; k < DEPTH + 3; k++)
			issue(4'($urandom_range(0, 9)), 4'($urandom), 2'($urandom), 3'd0, 2, k < DEPTH);
		idle(4);
		wb_read(trace_pkg::REG_STATUS, d);
		check_value("overflow status", status_word(DEPTH, 1'b1), d);
		wb_write(trace_pkg::REG_STATUS, 32'h200);
		wb_read(trace_pkg::REG_STATUS, d);
		check_value("overflow clear", status_word(DEPTH, 1'b0), d);
		check_records("overflow");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/trace_pkg.sv
rtl/exec_stage_capture.sv
rtl/instr_decoder.sv
rtl/trace_fifo.sv
rtl/trace_wb_slave.sv
rtl/instr_trace_top.sv
tb/instr_trace_tb.sv
